/* include/dbg_defs.svh */
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// ************************************************************
// Widths of the CPU snapshot and of the text path
// ************************************************************

`define DBG_CHAR_W      8       // One ASCII byte
`define DBG_NIBBLE_W    4
`define DBG_PC_W        20      // PC and return-stack entries
`define DBG_PC_DIGITS   5
`define DBG_RSTK_PTR_W  3
`define DBG_ST_W        16
`define DBG_HST_W       4
`define DBG_C_DIGITS    16
`define DBG_DIGIT_W     4       // Digit counter, covers all C nibbles

// ************************************************************
// Text buffer and serial link
// ************************************************************

`define DBG_BUF_DEPTH   512
`define DBG_ADDR_W      9
`define DBG_CREDITS     4       // Credits held by the transmitter after reset

`endif

/* hw/dbg_pkg.sv */
`include "dbg_defs.svh"

package dbg_pkg;

    typedef logic [`DBG_CHAR_W-1:0]   char_t;
    typedef logic [`DBG_NIBBLE_W-1:0] nibble_t;
    typedef logic [`DBG_ADDR_W-1:0]   addr_t;

    // What one entry of the field table emits
    typedef enum logic [2:0] {
        FK_LITERAL,     // Fixed text from the literal ROM
        FK_PC_HEX,
        FK_RSTK_HEX,    // Return-stack entry named by the argument
        FK_C_HEX,       // C register through the nibble port
        FK_BITS_HST,
        FK_BITS_ST,
        FK_SINGLE,      // 0 carry, 1 P, 2 rstk pointer
        FK_MODE         // HEX or DEC
    } field_kind_e;

    // One field-table entry, 16 bits
    typedef struct packed {
        field_kind_e kind;
        logic [5:0]  lit_idx;   // Start in the literal ROM
        logic [6:0]  arg;       // Literal length, or source selector
    } field_t;

endpackage

/* hw/dump_sequencer.sv */
`timescale 1ns/100ps
`include "dbg_defs.svh"

module dump_sequencer (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  logic                        i_tx_done,
    output logic                        o_busy,
    output dbg_pkg::field_kind_e        o_kind,
    output logic [`DBG_RSTK_PTR_W-1:0]  o_arg,
    output logic [`DBG_DIGIT_W-1:0]     o_digit_idx,
    output dbg_pkg::char_t              o_lit_char,
    output dbg_pkg::addr_t              o_wr_addr,
    output logic                        o_fmt_valid,
    output logic                        o_tx_start,
    output dbg_pkg::addr_t              o_last_addr
);

    typedef logic [`DBG_DIGIT_W-1:0] digit_t;
    typedef enum logic [1:0] {S_IDLE, S_FORMAT, S_SEND} state_e;

    localparam int NUM_FIELDS = 26;
    localparam int LIT_LEN    = 58;

    // ************************************************************
    // Literal text, first character in the top byte
    // ************************************************************
    // \012 is LF and \015 is CR
    localparam logic [`DBG_CHAR_W*LIT_LEN-1:0] LIT_TEXT = {
        "\012\015PC: ", " Carry: ", " h: ", " rp: ", " RSTK7: ",
        "\012\015P: ", " HST: ", " ST: ", "6: ", "\012\015C: ", "0: "
    };

    localparam dbg_pkg::field_t FIELD_ROM [NUM_FIELDS] = '{
        '{dbg_pkg::FK_LITERAL,  6'd0,  7'd6},   // LF CR "PC: "
        '{dbg_pkg::FK_PC_HEX,   6'd0,  7'd0},
        '{dbg_pkg::FK_LITERAL,  6'd6,  7'd8},   // " Carry: "
        '{dbg_pkg::FK_SINGLE,   6'd0,  7'd0},
        '{dbg_pkg::FK_LITERAL,  6'd14, 7'd4},   // " h: "
        '{dbg_pkg::FK_MODE,     6'd0,  7'd0},
        '{dbg_pkg::FK_LITERAL,  6'd18, 7'd5},   // " rp: "
        '{dbg_pkg::FK_SINGLE,   6'd0,  7'd2},
        '{dbg_pkg::FK_LITERAL,  6'd23, 7'd8},   // " RSTK7: "
        '{dbg_pkg::FK_RSTK_HEX, 6'd0,  7'd7},
        '{dbg_pkg::FK_LITERAL,  6'd31, 7'd5},   // LF CR "P: "
        '{dbg_pkg::FK_SINGLE,   6'd0,  7'd1},
        '{dbg_pkg::FK_LITERAL,  6'd36, 7'd6},   // " HST: "
        '{dbg_pkg::FK_BITS_HST, 6'd0,  7'd0},
        '{dbg_pkg::FK_LITERAL,  6'd42, 7'd5},   // " ST: "
        '{dbg_pkg::FK_BITS_ST,  6'd0,  7'd0},
        '{dbg_pkg::FK_LITERAL,  6'd23, 7'd5},   // " RSTK" shared with RSTK7
        '{dbg_pkg::FK_LITERAL,  6'd47, 7'd3},   // "6: "
        '{dbg_pkg::FK_RSTK_HEX, 6'd0,  7'd6},
        '{dbg_pkg::FK_LITERAL,  6'd50, 7'd5},   // LF CR "C: "
        '{dbg_pkg::FK_C_HEX,    6'd0,  7'd0},
        '{dbg_pkg::FK_LITERAL,  6'd0,  7'd2},   // LF CR
        '{dbg_pkg::FK_LITERAL,  6'd24, 7'd4},   // "RSTK"
        '{dbg_pkg::FK_LITERAL,  6'd55, 7'd3},   // "0: "
        '{dbg_pkg::FK_RSTK_HEX, 6'd0,  7'd0},
        '{dbg_pkg::FK_LITERAL,  6'd0,  7'd2}    // Closing LF CR
    };

    // Index of the first digit of a field, digits count down to zero
    function automatic digit_t last_digit(dbg_pkg::field_t f);
        case (f.kind)
            dbg_pkg::FK_LITERAL:  return digit_t'(f.arg - 7'd1);
            dbg_pkg::FK_PC_HEX,
            dbg_pkg::FK_RSTK_HEX: return digit_t'(`DBG_PC_DIGITS - 1);
            dbg_pkg::FK_C_HEX:    return digit_t'(`DBG_C_DIGITS - 1);
            dbg_pkg::FK_BITS_HST: return digit_t'(`DBG_HST_W - 1);
            dbg_pkg::FK_BITS_ST:  return digit_t'(`DBG_ST_W - 1);
            dbg_pkg::FK_MODE:     return digit_t'(2);
            default:              return '0;
        endcase
    endfunction

    state_e                        state;
    logic [$clog2(NUM_FIELDS)-1:0] field_idx;
    digit_t                        cnt;
    dbg_pkg::field_t               cur;
    logic [5:0]                    lit_pos;
    logic                          field_end;
    logic                          dump_end;

    assign cur       = FIELD_ROM[field_idx];
    assign field_end = (cnt == '0);
    assign dump_end  = field_end && (field_idx == NUM_FIELDS - 1);
    assign lit_pos   = cur.lit_idx + (last_digit(cur) - cnt);     // Literals read forward

    assign o_busy      = (state != S_IDLE);
    assign o_fmt_valid = (state == S_FORMAT);
    assign o_kind      = cur.kind;
    assign o_arg       = cur.arg[`DBG_RSTK_PTR_W-1:0];
    assign o_digit_idx = cnt;
    assign o_lit_char  = LIT_TEXT[`DBG_CHAR_W*(LIT_LEN-1-lit_pos) +: `DBG_CHAR_W];

    always_ff @(posedge i_clk) begin
        o_tx_start <= 1'b0;                         // Single-cycle pulse
        if (i_reset) begin
            state     <= S_IDLE;
            field_idx <= '0;
            cnt       <= '0;
            o_wr_addr <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state     <= S_FORMAT;
                        field_idx <= '0;
                        cnt       <= last_digit(FIELD_ROM[0]);
                        o_wr_addr <= '0;
                    end
                end
                S_FORMAT: begin
                    o_wr_addr <= o_wr_addr + 1'b1;  // One character per cycle
                    if (dump_end) begin
                        state      <= S_SEND;
                        o_tx_start <= 1'b1;
                    end else if (field_end) begin
                        field_idx <= field_idx + 1'b1;
                        cnt       <= last_digit(FIELD_ROM[field_idx + 1'b1]);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_SEND: begin
                    if (i_tx_done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_fmt_valid && dump_end) begin
            o_last_addr <= o_wr_addr;               // Held until the next dump
        end
    end

    // Within one dump the write address only climbs, so the text never wraps the buffer
    a_wr_addr_no_wrap: assert property (@(posedge i_clk) disable iff (i_reset)
        o_fmt_valid ##1 o_fmt_valid |-> o_wr_addr > $past(o_wr_addr));

endmodule

/* hw/field_formatter.sv */
`timescale 1ns/100ps
`include "dbg_defs.svh"

module field_formatter (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  dbg_pkg::field_kind_e        i_kind,
    input  logic [`DBG_RSTK_PTR_W-1:0]  i_arg,
    input  logic [`DBG_DIGIT_W-1:0]     i_digit_idx,
    input  dbg_pkg::char_t              i_lit_char,
    input  dbg_pkg::addr_t              i_wr_addr,
    input  logic                        i_fmt_valid,
    input  logic [`DBG_PC_W-1:0]        i_current_pc,
    input  logic                        i_carry,
    input  logic                        i_alu_mode,
    input  logic [`DBG_RSTK_PTR_W-1:0]  i_rstk_ptr,
    input  dbg_pkg::nibble_t            i_reg_p,
    input  logic [`DBG_HST_W-1:0]       i_reg_hst,
    input  logic [`DBG_ST_W-1:0]        i_reg_st,
    input  logic [`DBG_PC_W-1:0]        i_rstk_val,
    input  dbg_pkg::nibble_t            i_c_nibble,
    output logic [`DBG_RSTK_PTR_W-1:0]  o_rstk_sel,
    output logic [`DBG_DIGIT_W-1:0]     o_c_nibble_sel,
    output logic                        o_wr_en,
    output dbg_pkg::addr_t              o_wr_addr,
    output dbg_pkg::char_t              o_wr_char
);

    // Uppercase hex digit
    function automatic dbg_pkg::char_t hex_char(dbg_pkg::nibble_t n);
        return (n < 4'd10) ? "0" + n : "A" - 8'd10 + n;
    endfunction

    dbg_pkg::nibble_t nibble;
    dbg_pkg::char_t   ch;

    // CPU read ports are combinational, the value answers in the same cycle
    assign o_rstk_sel     = (i_fmt_valid && i_kind == dbg_pkg::FK_RSTK_HEX) ? i_arg : '0;
    assign o_c_nibble_sel = (i_fmt_valid && i_kind == dbg_pkg::FK_C_HEX) ? i_digit_idx : '0;

    // ************************************************************
    // Source nibble for the current digit
    // ************************************************************
    always_comb begin
        nibble = '0;
        case (i_kind)
            dbg_pkg::FK_PC_HEX:   nibble = i_current_pc[i_digit_idx*`DBG_NIBBLE_W +: `DBG_NIBBLE_W];
            dbg_pkg::FK_RSTK_HEX: nibble = i_rstk_val[i_digit_idx*`DBG_NIBBLE_W +: `DBG_NIBBLE_W];
            dbg_pkg::FK_C_HEX:    nibble = i_c_nibble;
            dbg_pkg::FK_BITS_HST: nibble = {3'b000, i_reg_hst[i_digit_idx[1:0]]};
            dbg_pkg::FK_BITS_ST:  nibble = {3'b000, i_reg_st[i_digit_idx]};
            dbg_pkg::FK_SINGLE: begin
                case (i_arg)
                    3'd0:    nibble = {3'b000, i_carry};
                    3'd1:    nibble = i_reg_p;
                    default: nibble = {1'b0, i_rstk_ptr};
                endcase
            end
            default: nibble = '0;
        endcase
    end

    always_comb begin
        case (i_kind)
            dbg_pkg::FK_LITERAL: ch = i_lit_char;
            dbg_pkg::FK_MODE: begin
                case (i_digit_idx)
                    4'd2:    ch = i_alu_mode ? "D" : "H";
                    4'd1:    ch = "E";
                    default: ch = i_alu_mode ? "C" : "X";
                endcase
            end
            default: ch = hex_char(nibble);
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= i_fmt_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wr_addr <= i_wr_addr;                     // Buffer write one cycle later
        o_wr_char <= ch;
    end

endmodule

/* hw/text_buffer.sv */
`timescale 1ns/100ps
`include "dbg_defs.svh"

module text_buffer (
    input  logic            i_clk,
    input  logic            i_wr_en,
    input  dbg_pkg::addr_t  i_wr_addr,
    input  dbg_pkg::char_t  i_wr_char,
    input  logic            i_rd_en,
    input  dbg_pkg::addr_t  i_rd_addr,
    output dbg_pkg::char_t  o_rd_char
);

    dbg_pkg::char_t mem [`DBG_BUF_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_char;
        end
        if (i_rd_en) begin
            o_rd_char <= mem[i_rd_addr];            // Data one cycle after the read
        end
    end

endmodule

/* hw/credit_tx.sv */
`timescale 1ns/100ps
`include "dbg_defs.svh"

module credit_tx (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_tx_start,
    input  dbg_pkg::addr_t  i_last_addr,
    input  dbg_pkg::char_t  i_rd_char,
    input  logic            i_credit_return,
    output logic            o_rd_en,
    output dbg_pkg::addr_t  o_rd_addr,
    output logic            o_char_valid,
    output dbg_pkg::char_t  o_char_data,
    output logic            o_tx_done
);

    localparam int CRED_W = $clog2(`DBG_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    logic              active;
    logic              last_rd;

    // The read issued last cycle already owns one of the credits
    assign o_rd_en     = active && (credits > {{(CRED_W-1){1'b0}}, o_char_valid});
    assign last_rd     = (o_rd_addr == i_last_addr);
    assign o_char_data = i_rd_char;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            active       <= 1'b0;
            o_rd_addr    <= '0;
            o_char_valid <= 1'b0;
            o_tx_done    <= 1'b0;
            credits      <= CRED_W'(`DBG_CREDITS);
        end else begin
            o_char_valid <= o_rd_en;
            o_tx_done    <= o_rd_en && last_rd;     // Lines up with the last character
            credits      <= credits - o_char_valid + i_credit_return;
            if (i_tx_start) begin
                active    <= 1'b1;
                o_rd_addr <= '0;
            end else if (o_rd_en) begin
                o_rd_addr <= o_rd_addr + 1'b1;
                if (last_rd) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Sink returns at most what it received
    a_credit_max: assert property (@(posedge i_clk) disable iff (i_reset)
        credits <= `DBG_CREDITS);

    a_valid_has_credit: assert property (@(posedge i_clk) disable iff (i_reset)
        o_char_valid |-> credits != '0);

endmodule

/* hw/reg_dump_top.sv */
`timescale 1ns/100ps
`include "dbg_defs.svh"

module reg_dump_top (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_start,
    output logic                        o_busy,
    input  logic [`DBG_PC_W-1:0]        i_current_pc,
    input  logic                        i_carry,
    input  logic                        i_alu_mode,
    input  logic [`DBG_RSTK_PTR_W-1:0]  i_rstk_ptr,
    input  dbg_pkg::nibble_t            i_reg_p,
    input  logic [`DBG_HST_W-1:0]       i_reg_hst,
    input  logic [`DBG_ST_W-1:0]        i_reg_st,
    output logic [`DBG_RSTK_PTR_W-1:0]  o_rstk_sel,
    input  logic [`DBG_PC_W-1:0]        i_rstk_val,
    output logic [`DBG_DIGIT_W-1:0]     o_c_nibble_sel,
    input  dbg_pkg::nibble_t            i_c_nibble,
    output logic                        o_char_valid,
    output dbg_pkg::char_t              o_char_data,
    input  logic                        i_credit_return
);

    dbg_pkg::field_kind_e        kind;
    logic [`DBG_RSTK_PTR_W-1:0]  arg;
    logic [`DBG_DIGIT_W-1:0]     digit_idx;
    dbg_pkg::char_t              lit_char;
    dbg_pkg::addr_t              fmt_addr;
    logic                        fmt_valid;
    logic                        tx_start;
    logic                        tx_done;
    dbg_pkg::addr_t              last_addr;
    logic                        wr_en;
    dbg_pkg::addr_t              wr_addr;
    dbg_pkg::char_t              wr_char;
    logic                        rd_en;
    dbg_pkg::addr_t              rd_addr;
    dbg_pkg::char_t              rd_char;

    dump_sequencer u_seq (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(i_start), .i_tx_done(tx_done),
        .o_busy(o_busy), .o_kind(kind), .o_arg(arg), .o_digit_idx(digit_idx),
        .o_lit_char(lit_char), .o_wr_addr(fmt_addr), .o_fmt_valid(fmt_valid),
        .o_tx_start(tx_start), .o_last_addr(last_addr)
    );

    field_formatter u_fmt (
        .i_clk(i_clk), .i_reset(i_reset), .i_kind(kind), .i_arg(arg),
        .i_digit_idx(digit_idx), .i_lit_char(lit_char), .i_wr_addr(fmt_addr),
        .i_fmt_valid(fmt_valid), .i_current_pc(i_current_pc), .i_carry(i_carry),
        .i_alu_mode(i_alu_mode), .i_rstk_ptr(i_rstk_ptr), .i_reg_p(i_reg_p),
        .i_reg_hst(i_reg_hst), .i_reg_st(i_reg_st), .i_rstk_val(i_rstk_val),
        .i_c_nibble(i_c_nibble), .o_rstk_sel(o_rstk_sel), .o_c_nibble_sel(o_c_nibble_sel),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_char(wr_char)
    );

    text_buffer u_buf (
        .i_clk(i_clk), .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_char(wr_char),
        .i_rd_en(rd_en), .i_rd_addr(rd_addr), .o_rd_char(rd_char)
    );

    credit_tx u_tx (
        .i_clk(i_clk), .i_reset(i_reset), .i_tx_start(tx_start), .i_last_addr(last_addr),
        .i_rd_char(rd_char), .i_credit_return(i_credit_return), .o_rd_en(rd_en),
        .o_rd_addr(rd_addr), .o_char_valid(o_char_valid), .o_char_data(o_char_data),
        .o_tx_done(tx_done)
    );

endmodule

/* verif/tb_dump_model_pkg.sv */
`include "dbg_defs.svh"

package tb_dump_model_pkg;

    localparam int NUM_HEX = 39;                // Hex digits in one dump

    typedef struct packed {
        logic [`DBG_PC_W-1:0]              pc;
        logic                              carry;
        logic                              mode;
        logic [`DBG_RSTK_PTR_W-1:0]        rp;
        dbg_pkg::nibble_t                  p;
        logic [`DBG_HST_W-1:0]             hst;
        logic [`DBG_ST_W-1:0]              st;
        logic [7:0][`DBG_PC_W-1:0]         rstk;
        logic [`DBG_C_DIGITS*4-1:0]        c;
    } cpu_state_t;

    // Fixed width uppercase hex with the most significant digit first
    function automatic string hex_text(input logic [63:0] v, input int digits);
        string s;
        s = $sformatf("%h", v);
        s = s.substr(16 - digits, 15);
        return s.toupper();
    endfunction

    // Kind letters run in step with the text (t text, h hex digit, b bit)
    function automatic void add_part(inout string text, inout string kinds,
                                     input string part, input string kind);
        int i;
        text = {text, part};
        for (i = 0; i < part.len(); i++) begin
            kinds = {kinds, kind};
        end
    endfunction

    function automatic void build_dump(input cpu_state_t s, output string text,
                                       output string kinds);
        text  = "";
        kinds = "";
        add_part(text, kinds, "\012\015PC: ", "t");
        add_part(text, kinds, hex_text(s.pc, 5), "h");
        add_part(text, kinds, " Carry: ", "t");
        add_part(text, kinds, hex_text(s.carry, 1), "h");
        add_part(text, kinds, " h: ", "t");
        add_part(text, kinds, s.mode ? "DEC" : "HEX", "t");
        add_part(text, kinds, " rp: ", "t");
        add_part(text, kinds, hex_text(s.rp, 1), "h");
        add_part(text, kinds, " RSTK7: ", "t");
        add_part(text, kinds, hex_text(s.rstk[7], 5), "h");
        add_part(text, kinds, "\012\015P: ", "t");
        add_part(text, kinds, hex_text(s.p, 1), "h");
        add_part(text, kinds, " HST: ", "t");
        add_part(text, kinds, $sformatf("%b", s.hst), "b");
        add_part(text, kinds, " ST: ", "t");
        add_part(text, kinds, $sformatf("%b", s.st), "b");
        add_part(text, kinds, " RSTK6: ", "t");
        add_part(text, kinds, hex_text(s.rstk[6], 5), "h");
        add_part(text, kinds, "\012\015C: ", "t");
        add_part(text, kinds, hex_text(s.c, 16), "h");
        add_part(text, kinds, "\012\015RSTK0: ", "t");
        add_part(text, kinds, hex_text(s.rstk[0], 5), "h");
        add_part(text, kinds, "\012\015", "t");
    endfunction

    // Every hex digit of the dump in text order with the first digit in the top nibble
    function automatic logic [NUM_HEX*4-1:0] hex_nibbles(input cpu_state_t s);
        return {s.pc, 3'b000, s.carry, 1'b0, s.rp, s.rstk[7], s.p, s.rstk[6],
                s.c, s.rstk[0]};
    endfunction

endpackage

/* verif/tb_reg_dump.sv */
`timescale 1ns/100ps
`include "dbg_defs.svh"

module tb_reg_dump;

    localparam int BUSY_LIMIT = 6000;           // Cycles for one dump at the slowest sink

    logic                          i_clk;
    logic                          i_reset;
    logic                          i_start;
    logic                          i_credit_return;
    logic                          o_busy;
    logic                          o_char_valid;
    dbg_pkg::char_t                o_char_data;
    logic [`DBG_RSTK_PTR_W-1:0]    o_rstk_sel;
    logic [`DBG_DIGIT_W-1:0]       o_c_nibble_sel;
    logic [`DBG_PC_W-1:0]          rstk_val;
    dbg_pkg::nibble_t              c_nibble;
    tb_dump_model_pkg::cpu_state_t cpu;
    dbg_pkg::char_t                rx_q [$];
    int                            in_flight;
    int                            ret_wait;
    int                            max_delay;
    int                            seed_val;
    int                            n;

    // CPU side read ports answer in the same cycle
    assign rstk_val = cpu.rstk[o_rstk_sel];
    assign c_nibble = cpu.c[o_c_nibble_sel*4 +: 4];

    reg_dump_top DUT (
        .i_clk(i_clk), .i_reset(i_reset), .i_start(i_start), .o_busy(o_busy),
        .i_current_pc(cpu.pc), .i_carry(cpu.carry), .i_alu_mode(cpu.mode),
        .i_rstk_ptr(cpu.rp), .i_reg_p(cpu.p), .i_reg_hst(cpu.hst), .i_reg_st(cpu.st),
        .o_rstk_sel(o_rstk_sel), .i_rstk_val(rstk_val), .o_c_nibble_sel(o_c_nibble_sel),
        .i_c_nibble(c_nibble), .o_char_valid(o_char_valid), .o_char_data(o_char_data),
        .i_credit_return(i_credit_return)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // ************************************************************
    // Credit sink returns one credit per character after a delay
    // ************************************************************
    always @(negedge i_clk) begin
        i_credit_return <= 1'b0;
        if (i_reset) begin
            in_flight = 0;                      // Transmitter reloads its credits
            ret_wait  = 0;
        end else begin
            if (o_char_valid) begin
                rx_q.push_back(o_char_data);
                in_flight++;
                if (in_flight > `DBG_CREDITS) begin
                    stop_run("More characters in flight than credits granted");
                end
            end
            if (in_flight > 0 && ret_wait == 0) begin
                i_credit_return <= 1'b1;
                in_flight--;
                ret_wait = $urandom % (max_delay + 1);
            end else if (ret_wait > 0) begin
                ret_wait--;
            end
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_char(input int idx, input dbg_pkg::char_t got,
                              input dbg_pkg::char_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED o_char_data[%0d]: got %h, expected %h", idx, got, exp));
        end
    endtask

    task automatic check_nibble(input int idx, input dbg_pkg::nibble_t got,
                                input dbg_pkg::nibble_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED hex digit %0d of o_char_data: got %h, expected %h",
                               idx, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("FAILED o_char_valid count: got %h, expected %h", got, exp));
        end
    endtask

    function automatic dbg_pkg::nibble_t to_nibble(input dbg_pkg::char_t c);
        if (c >= "A") begin
            return dbg_pkg::nibble_t'(c - "A" + 10);
        end
        return dbg_pkg::nibble_t'(c - "0");
    endfunction

    task automatic apply_reset();
        i_reset <= 1'b1;
        i_start <= 1'b0;
        repeat (8) @(negedge i_clk);
        i_reset <= 1'b0;
    endtask

    task automatic randomize_cpu();
        int i;
        cpu.pc    = $urandom;
        cpu.carry = $urandom;
        cpu.mode  = $urandom;
        cpu.rp    = $urandom;
        cpu.p     = $urandom;
        cpu.hst   = $urandom;
        cpu.st    = $urandom;
        for (i = 0; i < 8; i++) begin
            cpu.rstk[i] = $urandom;
        end
        cpu.c = {$urandom, $urandom};
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge i_clk);
            cycles++;
            if (cycles > limit) begin
                stop_run("o_busy did not reach the expected level in time");
            end
        end while (o_busy !== level);
    endtask

    task automatic run_dump(input bit extra_start);
        string                                   text;
        string                                   kinds;
        logic [tb_dump_model_pkg::NUM_HEX*4-1:0] nibs;
        int                                      i;
        int                                      k;
        rx_q.delete();
        i_start <= 1'b1;
        wait_busy(1'b1, 1);                     // Busy the cycle after the start
        i_start <= 1'b0;
        if (extra_start) begin                  // Must be ignored while busy
            repeat ($urandom % 60) @(negedge i_clk);
            i_start <= 1'b1;
            @(negedge i_clk);
            i_start <= 1'b0;
        end
        wait_busy(1'b0, BUSY_LIMIT);
        tb_dump_model_pkg::build_dump(cpu, text, kinds);
        nibs = tb_dump_model_pkg::hex_nibbles(cpu);
        check_count(rx_q.size(), text.len());
        k = 0;
        for (i = 0; i < text.len(); i++) begin
            if (kinds.getc(i) == "h") begin
                check_nibble(k, to_nibble(rx_q[i]),
                             nibs[(tb_dump_model_pkg::NUM_HEX-1-k)*4 +: 4]);
                k++;
            end
            check_char(i, rx_q[i], text.getc(i));
        end
    endtask

    // ************************************************************
    // Test sequence
    // ************************************************************
    initial begin
        seed_val        = $urandom(32'h332a_3d34);
        i_reset         = 1'b1;
        i_start         = 1'b0;
        i_credit_return = 1'b0;
        cpu             = '0;
        max_delay       = 0;
        apply_reset();

        repeat (100) begin                      // Idle link without a start
            @(negedge i_clk);
            if (o_char_valid || o_busy) begin
                stop_run("Link active after reset without a start");
            end
        end

        for (n = 0; n < 24; n++) begin
            max_delay = (n % 3 == 0) ? 0 : $urandom % 16;
            randomize_cpu();
            run_dump(n % 4 == 3);
        end

        // Reset somewhere in formatting or sending
        max_delay = 8;
        randomize_cpu();
        i_start <= 1'b1;
        wait_busy(1'b1, 1);
        i_start <= 1'b0;
        repeat (20 + $urandom % 200) @(negedge i_clk);
        apply_reset();
        if (o_busy || o_char_valid) begin
            stop_run("o_busy or o_char_valid still high after reset");
        end
        randomize_cpu();
        run_dump(1'b0);

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hw/dbg_pkg.sv
hw/dump_sequencer.sv
hw/field_formatter.sv
hw/text_buffer.sv
hw/credit_tx.sv
hw/reg_dump_top.sv
verif/tb_dump_model_pkg.sv
verif/tb_reg_dump.sv
